/* src/bno_pkg.sv */
`default_nettype none

package bno_pkg;

    // SHTP channels
    localparam logic [7:0] CHANNEL_CONTROL = 8'h02;
    localparam logic [7:0] CHANNEL_REPORTS = 8'h03;
    localparam logic [7:0] CHANNEL_GYRO_RV = 8'h05;

    localparam logic [7:0] REPORT_ID_ROTATION_VECTOR = 8'h05;
    localparam logic [7:0] REPORT_ID_GYROSCOPE       = 8'h02;
    localparam logic [7:0] REPORT_ID_SET_FEATURE     = 8'hFD;
    localparam logic [7:0] REPORT_ID_PRODUCT_ID_REQ  = 8'hF9;

    localparam logic [31:0] REPORT_INTERVAL_US = 32'd20000; // 50 Hz

    localparam int SHTP_HEADER_BYTES = 4;
    localparam int NUM_INIT_CMDS     = 3;

    typedef struct packed {
        logic       start;
        logic [7:0] tx_data;
    } spi_cmd_t;

    typedef struct packed {
        logic       done;
        logic [7:0] rx_data;
    } spi_resp_t;

    typedef struct packed {
        logic [7:0] data;
        logic [7:0] channel;
        logic       first;   // Payload offset 0
    } shtp_byte_t;

    typedef enum logic {
        ROTATION,
        GYRO
    } report_kind_t;

    typedef struct packed {
        report_kind_t       kind;
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
        logic signed [15:0] w;   // Zero for gyro
    } sensor_report_t;

    // Total bytes of init command including header
    function automatic logic [7:0] cmd_len(input logic [1:0] step);
        case (step)
            2'd0:    return 8'd5;
            2'd1:    return 8'd17;
            2'd2:    return 8'd17;
            default: return 8'd0;
        endcase
    endfunction

    function automatic logic [7:0] cmd_byte(input logic [1:0] step, input logic [7:0] idx);
        logic [7:0] b;
        b = 8'h00;
        case (idx)
            8'd0: b = cmd_len(step);  // Length LSB
            8'd2: b = CHANNEL_CONTROL;
            8'd3: b = {6'd0, step};   // Sequence number
            8'd4: b = (step == 2'd0) ? REPORT_ID_PRODUCT_ID_REQ : REPORT_ID_SET_FEATURE;
            8'd5: begin
                if (step == 2'd1) begin
                    b = REPORT_ID_ROTATION_VECTOR;
                end else if (step == 2'd2) begin
                    b = REPORT_ID_GYROSCOPE;
                end
            end
            // Report interval in little-endian order
            8'd9:  b = (step != 2'd0) ? REPORT_INTERVAL_US[7:0] : 8'h00;
            8'd10: b = (step != 2'd0) ? REPORT_INTERVAL_US[15:8] : 8'h00;
            8'd11: b = (step != 2'd0) ? REPORT_INTERVAL_US[23:16] : 8'h00;
            8'd12: b = (step != 2'd0) ? REPORT_INTERVAL_US[31:24] : 8'h00;
            default: b = 8'h00;
        endcase
        return b;
    endfunction

endpackage

`default_nettype wire

/* src/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign in_ready  = (count != (AW+1)'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr]; // Head entry stays put until popped
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

/* src/shtp_link_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module shtp_link_ctrl import bno_pkg::*; #(
    parameter int unsigned POWERUP_CYCLES = 1000,
    parameter int unsigned WAKE_CYCLES    = 16,
    parameter int unsigned CMD_GAP_CYCLES = 100
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       int_n,
    output spi_cmd_t   spi_cmd,
    input  spi_resp_t  spi_resp,
    output logic       cs_n,
    output logic       ps0_wake,
    output logic       initialized,
    output shtp_byte_t byte_out,
    output logic       byte_valid,
    input  logic       byte_ready
);

    typedef enum logic [3:0] {
        ST_POWERUP,
        ST_WAKE,
        ST_WAIT_INT,
        ST_CS_SETUP,
        ST_SEND,
        ST_GAP,
        ST_IDLE,
        ST_READ_SETUP,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    state_t      state;
    logic        int_meta;
    logic        int_sync;
    logic [31:0] timer;
    logic [1:0]  step;      // Init command index
    logic [15:0] idx;       // Byte index within command, header or payload
    logic [15:0] pkt_len;
    logic [7:0]  channel;
    logic        pending;   // Byte outstanding at the SPI master
    logic        start_q;
    logic        last_payload;

    assign last_payload = (idx == pkt_len - 16'(SHTP_HEADER_BYTES + 1));

    // Command bytes while sending, zeros while reading
    assign spi_cmd = '{
        start:   start_q,
        tx_data: (state == ST_SEND) ? cmd_byte(step, idx[7:0]) : 8'h00
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b1;
            int_sync <= 1'b1;
        end else begin
            int_meta <= int_n;
            int_sync <= int_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_POWERUP;
            timer       <= '0;
            step        <= 2'd0;
            idx         <= '0;
            pkt_len     <= '0;
            channel     <= '0;
            pending     <= 1'b0;
            start_q     <= 1'b0;
            cs_n        <= 1'b1;
            ps0_wake    <= 1'b1;
            initialized <= 1'b0;
            byte_valid  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (byte_valid && byte_ready) begin
                byte_valid <= 1'b0;
            end

            case (state)
                ST_POWERUP: begin
                    if (timer < POWERUP_CYCLES) begin
                        timer <= timer + 32'd1;
                    end else begin
                        timer <= '0;
                        state <= ST_WAKE;
                    end
                end

                ST_WAKE: begin
                    ps0_wake <= 1'b0; // Active low
                    if (timer < WAKE_CYCLES) begin
                        timer <= timer + 32'd1;
                    end else begin
                        timer <= '0;
                        state <= ST_WAIT_INT;
                    end
                end

                ST_WAIT_INT: if (!int_sync) state <= ST_CS_SETUP;

                ST_CS_SETUP: begin
                    cs_n     <= 1'b0;
                    ps0_wake <= 1'b1;  // Wake released once CS is low
                    idx      <= '0;
                    state    <= ST_SEND;
                end

                ST_SEND: begin
                    if (spi_resp.done) begin
                        pending <= 1'b0;
                        if (idx[7:0] == cmd_len(step) - 8'd1) begin
                            cs_n  <= 1'b1;
                            timer <= '0;
                            state <= ST_GAP;
                        end else begin
                            idx <= idx + 16'd1;
                        end
                    end else if (!pending) begin
                        start_q <= 1'b1;
                        pending <= 1'b1;
                    end
                end

                ST_GAP: begin
                    if (timer < CMD_GAP_CYCLES) begin
                        timer <= timer + 32'd1;
                    end else if (step == 2'(NUM_INIT_CMDS - 1)) begin
                        initialized <= 1'b1;
                        state       <= ST_IDLE;
                    end else begin
                        timer <= '0;
                        step  <= step + 2'd1;
                        state <= ST_WAKE;
                    end
                end

                ST_IDLE: if (!int_sync) state <= ST_READ_SETUP;

                ST_READ_SETUP: begin
                    cs_n  <= 1'b0;
                    idx   <= '0;
                    state <= ST_HEADER;
                end

                ST_HEADER: begin
                    if (spi_resp.done) begin
                        pending <= 1'b0;
                        case (idx[1:0])
                            2'd0: pkt_len[7:0] <= spi_resp.rx_data;
                            2'd1: pkt_len[15:8] <= {1'b0, spi_resp.rx_data[6:0]}; // Drop continuation
                            2'd2: channel <= spi_resp.rx_data;
                            default: ;  // Sequence number unused
                        endcase
                        if (idx == 16'(SHTP_HEADER_BYTES - 1)) begin
                            idx <= '0;
                            if (pkt_len > 16'(SHTP_HEADER_BYTES)) begin
                                state <= ST_PAYLOAD;
                            end else begin
                                cs_n  <= 1'b1;
                                state <= ST_IDLE;
                            end
                        end else begin
                            idx <= idx + 16'd1;
                        end
                    end else if (!pending) begin
                        start_q <= 1'b1;
                        pending <= 1'b1;
                    end
                end

                ST_PAYLOAD: begin
                    if (spi_resp.done) begin
                        pending    <= 1'b0;
                        byte_valid <= 1'b1;
                        if (last_payload) begin
                            cs_n  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            idx <= idx + 16'd1;
                        end
                    end else if (!pending && !byte_valid) begin
                        // Next byte waits until the previous one is buffered
                        start_q <= 1'b1;
                        pending <= 1'b1;
                    end
                end

                default: state <= ST_POWERUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_PAYLOAD && spi_resp.done) begin
            byte_out <= '{data: spi_resp.rx_data, channel: channel, first: (idx == 16'd0)};
        end
    end

endmodule

`default_nettype wire

/* src/sh_report_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module sh_report_parser import bno_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  shtp_byte_t     byte_in,
    input  logic           byte_valid,
    output logic           byte_ready,
    output sensor_report_t report_out,
    output logic           report_valid,
    input  logic           report_ready
);

    logic               take;
    logic               chan_ok;
    logic               cur_active;
    logic [3:0]         cur_off;
    logic               active;    // Packet still of interest
    logic [3:0]         offset;    // Saturates at 15
    logic               known_id;
    report_kind_t       kind;
    logic [7:0]         lsb;
    logic signed [15:0] x_q;
    logic signed [15:0] y_q;
    logic signed [15:0] z_q;
    logic [15:0]        word;
    logic               emit_gyro;
    logic               emit_rot;

    // Output slot frees up in the cycle it is taken
    assign byte_ready = !report_valid || report_ready;
    assign take       = byte_valid && byte_ready;

    assign chan_ok    = (byte_in.channel == CHANNEL_REPORTS) ||
                        (byte_in.channel == CHANNEL_GYRO_RV);
    assign cur_active = byte_in.first ? chan_ok : active;
    assign cur_off    = byte_in.first ? 4'd0 : offset;
    assign known_id   = (byte_in.data == REPORT_ID_ROTATION_VECTOR) ||
                        (byte_in.data == REPORT_ID_GYROSCOPE);
    assign word       = {byte_in.data, lsb};  // Little-endian pair

    assign emit_gyro = take && cur_active && (cur_off == 4'd9) && (kind == GYRO);
    assign emit_rot  = take && cur_active && (cur_off == 4'd11) && (kind == ROTATION);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active       <= 1'b0;
            offset       <= '0;
            report_valid <= 1'b0;
        end else begin
            if (report_valid && report_ready) report_valid <= 1'b0;
            if (emit_gyro || emit_rot) report_valid <= 1'b1;

            if (take) begin
                offset <= (cur_off == 4'hF) ? cur_off : cur_off + 4'd1;
                active <= cur_active;
                if (cur_off == 4'd0 && !known_id) begin
                    active <= 1'b0;
                end
                // One report per packet
                if (emit_gyro || emit_rot) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && cur_active) begin
            case (cur_off)
                4'd0: kind <= (byte_in.data == REPORT_ID_ROTATION_VECTOR) ? ROTATION : GYRO;
                4'd4, 4'd6, 4'd8, 4'd10: lsb <= byte_in.data;
                4'd5: x_q <= $signed(word);
                4'd7: y_q <= $signed(word);
                4'd9: z_q <= $signed(word);
                default: ;
            endcase
        end
        if (emit_gyro) begin
            report_out <= '{kind: GYRO, x: x_q, y: y_q, z: $signed(word), w: 16'sd0};
        end
        if (emit_rot) begin
            report_out <= '{kind: ROTATION, x: x_q, y: y_q, z: z_q, w: $signed(word)};
        end
    end

endmodule

`default_nettype wire

/* src/bno085_hub.sv */
`timescale 1ns/1ps
`default_nettype none

module bno085_hub import bno_pkg::*; #(
    parameter int unsigned POWERUP_CYCLES    = 300000,
    parameter int unsigned WAKE_CYCLES       = 450,
    parameter int unsigned CMD_GAP_CYCLES    = 30000,
    parameter int          BYTE_FIFO_DEPTH   = 16,
    parameter int          REPORT_FIFO_DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           int_n,
    output spi_cmd_t       spi_cmd,
    input  spi_resp_t      spi_resp,
    output logic           cs_n,
    output logic           ps0_wake,
    output logic           initialized,
    output sensor_report_t report,
    output logic           report_valid,
    input  logic           report_ready
);

    shtp_byte_t     ctrl_byte;
    logic           ctrl_byte_valid;
    logic           ctrl_byte_ready;
    shtp_byte_t     parse_byte;
    logic           parse_byte_valid;
    logic           parse_byte_ready;
    sensor_report_t parse_report;
    logic           parse_report_valid;
    logic           parse_report_ready;

    shtp_link_ctrl #(
        .POWERUP_CYCLES (POWERUP_CYCLES),
        .WAKE_CYCLES    (WAKE_CYCLES),
        .CMD_GAP_CYCLES (CMD_GAP_CYCLES)
    ) link_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .int_n       (int_n),
        .spi_cmd     (spi_cmd),
        .spi_resp    (spi_resp),
        .cs_n        (cs_n),
        .ps0_wake    (ps0_wake),
        .initialized (initialized),
        .byte_out    (ctrl_byte),
        .byte_valid  (ctrl_byte_valid),
        .byte_ready  (ctrl_byte_ready)
    );

    // Payload bytes between SPI reads and parsing
    stream_fifo #(
        .payload_t (shtp_byte_t),
        .DEPTH     (BYTE_FIFO_DEPTH)
    ) byte_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (ctrl_byte),
        .in_valid  (ctrl_byte_valid),
        .in_ready  (ctrl_byte_ready),
        .out_data  (parse_byte),
        .out_valid (parse_byte_valid),
        .out_ready (parse_byte_ready)
    );

    sh_report_parser report_parser_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_in      (parse_byte),
        .byte_valid   (parse_byte_valid),
        .byte_ready   (parse_byte_ready),
        .report_out   (parse_report),
        .report_valid (parse_report_valid),
        .report_ready (parse_report_ready)
    );

    stream_fifo #(
        .payload_t (sensor_report_t),
        .DEPTH     (REPORT_FIFO_DEPTH)
    ) report_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (parse_report),
        .in_valid  (parse_report_valid),
        .in_ready  (parse_report_ready),
        .out_data  (report),
        .out_valid (report_valid),
        .out_ready (report_ready)
    );

endmodule

`default_nettype wire

/* bench/bno085_hub_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module bno085_hub_sva import bno_pkg::*; (
    input logic           clk,
    input logic           rst_n,
    input spi_cmd_t       spi_cmd,
    input spi_resp_t      spi_resp,
    input logic           cs_n,
    input sensor_report_t report,
    input logic           report_valid,
    input logic           report_ready
);

    logic busy;  // Byte outstanding at the SPI master

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (spi_cmd.start) begin
            busy <= 1'b1;
        end else if (spi_resp.done) begin
            busy <= 1'b0;
        end
    end

    start_with_cs: assert property (@(posedge clk) disable iff (!rst_n)
        spi_cmd.start |-> !cs_n)
        else $error("SPI start while cs_n is high");

    report_hold: assert property (@(posedge clk) disable iff (!rst_n)
        report_valid && !report_ready |=> report_valid && $stable(report))
        else $error("report dropped or changed before report_ready");

    one_byte_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !spi_cmd.start)
        else $error("SPI start before done of the previous byte");

endmodule

bind bno085_hub bno085_hub_sva sva_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_cmd      (spi_cmd),
    .spi_resp     (spi_resp),
    .cs_n         (cs_n),
    .report       (report),
    .report_valid (report_valid),
    .report_ready (report_ready)
);

`default_nettype wire

/* bench/bno085_hub_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bno085_hub_tb import bno_pkg::*; ();

    localparam int POWERUP       = 20;
    localparam int WAKE          = 4;
    localparam int GAP           = 10;
    localparam int NUM_VEC       = 12;
    localparam int VEC_WORDS     = 13;
    localparam int MAX_PKT_BYTES = 20;
    localparam int BYTE_CYCLES   = 8;   // Worst SPI delay plus turnaround
    localparam int INIT_CYCLES   = POWERUP + 3 * (WAKE + GAP + 17 * BYTE_CYCLES + 8);
    localparam int TIMEOUT_CYCLES =
        2 * (INIT_CYCLES + NUM_VEC * (MAX_PKT_BYTES * BYTE_CYCLES + 16));

    logic           clk = 1'b0;
    logic           rst_n = 1'b0;
    logic           int_n = 1'b1;
    spi_cmd_t       spi_cmd;
    spi_resp_t      spi_resp = '0;
    logic           cs_n;
    logic           ps0_wake;
    logic           initialized;
    sensor_report_t report;
    logic           report_valid;
    logic           report_ready = 1'b0;

    logic [15:0]    vec_mem [NUM_VEC * VEC_WORDS];
    logic [7:0]     miso_q [$];   // Bytes of the packet being read
    sensor_report_t exp_q [$];
    logic [7:0]     lfsr = 8'd29;
    logic [7:0]     rx_byte = 8'h00;
    int             cycle = 0;
    int             wait_cnt = 0;
    int             vec_idx = 0;
    int             init_step = 0;
    int             init_idx = 0;
    int             cs_rises = 0;
    int             wake_falls = 0;
    logic           cs_prev = 1'b1;
    logic           wake_prev = 1'b1;
    logic           init_prev = 1'b0;
    logic           busy = 1'b0;
    logic           first_seen = 1'b0;
    logic           stream_done = 1'b0;

    bno085_hub #(
        .POWERUP_CYCLES    (POWERUP),
        .WAKE_CYCLES       (WAKE),
        .CMD_GAP_CYCLES    (GAP),
        .BYTE_FIFO_DEPTH   (4),
        .REPORT_FIFO_DEPTH (2)
    ) bno085_hub_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_n        (int_n),
        .spi_cmd      (spi_cmd),
        .spi_resp     (spi_resp),
        .cs_n         (cs_n),
        .ps0_wake     (ps0_wake),
        .initialized  (initialized),
        .report       (report),
        .report_valid (report_valid),
        .report_ready (report_ready)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int init_cmd_len(input int step);
        return (step == 0) ? 5 : 17;
    endfunction

    // Product ID request, then Set Feature for rotation vector and gyro
    function automatic logic [7:0] init_cmd_byte(input int step, input int idx);
        if (step == 0) begin
            case (idx)
                0:       return 8'h05;
                2:       return 8'h02;
                4:       return 8'hF9;
                default: return 8'h00;
            endcase
        end
        case (idx)
            0:       return 8'd17;
            2:       return 8'h02;
            3:       return 8'(step);
            4:       return 8'hFD;
            5:       return (step == 1) ? 8'h05 : 8'h02;
            9:       return 8'h20;  // 20000 us in little-endian order
            10:      return 8'h4E;
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] payload_byte(input int v, input int off);
        logic [15:0] field;
        if (off == 0) return vec_mem[v * VEC_WORDS + 2][7:0];  // Report ID
        if (off < 4 || off > 11) return 8'h00;
        field = vec_mem[v * VEC_WORDS + 3 + (off - 4) / 2];
        return (off % 2 == 0) ? field[7:0] : field[15:8];
    endfunction

    task automatic load_packet(input int v);
        int base;
        int len;
        int payload;
        sensor_report_t e;
        base    = v * VEC_WORDS;
        len     = int'(vec_mem[base + 1] & 16'h7FFF);
        payload = (len > 4) ? len - 4 : 0;
        miso_q.push_back(vec_mem[base + 1][7:0]);
        miso_q.push_back(vec_mem[base + 1][15:8]);
        miso_q.push_back(vec_mem[base][7:0]);  // Channel
        miso_q.push_back(8'(v));
        for (int i = 0; i < payload; i++) begin
            miso_q.push_back(payload_byte(v, i));
        end
        if (vec_mem[base + 7] != 16'h0000) begin
            e.kind = report_kind_t'(vec_mem[base + 8][0]);
            e.x    = vec_mem[base + 9];
            e.y    = vec_mem[base + 10];
            e.z    = vec_mem[base + 11];
            e.w    = vec_mem[base + 12];
            exp_q.push_back(e);
        end
    endtask

    initial begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // SPI master, sensor and report sink on the falling edge
    always @(negedge clk) begin
        logic           rdy;
        sensor_report_t e;
        if (cs_n && !cs_prev && !initialized) cs_rises++;
        cs_prev = cs_n;
        if (!ps0_wake && wake_prev && !initialized) wake_falls++;
        wake_prev = ps0_wake;
        if (initialized && !init_prev) begin
            check_value(init_step, NUM_INIT_CMDS, "commands sent before initialized");
            check_value(cs_rises, NUM_INIT_CMDS, "cs_n rises before initialized");
        end
        init_prev = initialized;

        rdy = (random_bits(2) != 0);
        report_ready <= rdy;
        if (!initialized) check_value(32'(report_valid), 32'd0, "report_valid before init");
        if (report_valid && rdy) begin
            if (exp_q.size() == 0) fail_run("DUT gave a report that no vector expects");
            e = exp_q.pop_front();
            check_value({31'd0, report.kind}, {31'd0, e.kind}, "report kind");
            check_value({16'd0, report.x}, {16'd0, e.x}, "report x");
            check_value({16'd0, report.y}, {16'd0, e.y}, "report y");
            check_value({16'd0, report.z}, {16'd0, e.z}, "report z");
            check_value({16'd0, report.w}, {16'd0, e.w}, "report w");
        end

        spi_resp <= '{done: 1'b0, rx_data: 8'h00};
        if (busy) begin
            if (wait_cnt == 1) begin
                spi_resp <= '{done: 1'b1, rx_data: rx_byte};
                busy = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
        if (spi_cmd.start) begin
            if (!first_seen && cycle < 5 + POWERUP + WAKE) begin
                fail_run("first command byte came before the power-up and wake delays");
            end
            first_seen = 1'b1;
            if (!initialized) begin
                if (init_step >= NUM_INIT_CMDS) fail_run("DUT sent a fourth init command");
                if (init_idx == 0) begin
                    check_value(cs_rises, init_step, "cs_n rises at command start");
                    check_value(wake_falls, init_step + 1, "wake pulses at command start");
                end
                check_value({24'd0, spi_cmd.tx_data}, {24'd0, init_cmd_byte(init_step, init_idx)},
                            $sformatf("command %0d byte %0d", init_step, init_idx));
                rx_byte = 8'h00;
                init_idx++;
                if (init_idx == init_cmd_len(init_step)) begin
                    init_idx = 0;
                    init_step++;
                end
            end else begin
                if (miso_q.size() == 0) fail_run("DUT read more bytes than the packet holds");
                check_value({24'd0, spi_cmd.tx_data}, 32'd0, "MOSI byte during read");
                rx_byte = miso_q.pop_front();
            end
            wait_cnt = random_bits(2) + 1;
            busy     = 1'b1;
        end

        if (initialized && vec_idx < NUM_VEC && miso_q.size() == 0 && cs_n && !busy) begin
            load_packet(vec_idx);
            vec_idx++;
        end
        if (!initialized) begin
            int_n <= ps0_wake;  // Hub answers wake with INT
        end else begin
            int_n <= !(miso_q.size() != 0 && cs_n);
        end
        if (vec_idx == NUM_VEC && miso_q.size() == 0 && cs_n && !busy &&
            exp_q.size() == 0 && !report_valid) begin
            stream_done = 1'b1;
        end
    end

    initial begin
        $readmemh("bench/bno085_hub_vectors.txt", vec_mem);
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_value(32'(cs_n), 32'd1, "cs_n in reset");
        check_value(32'(ps0_wake), 32'd1, "ps0_wake in reset");
        check_value(32'(spi_cmd.start), 32'd0, "start in reset");
        check_value(32'(initialized), 32'd0, "initialized in reset");
        check_value(32'(report_valid), 32'd0, "report_valid in reset");
        rst_n = 1'b1;
        @(posedge clk);
        while (!stream_done) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* bno085_hub.f */
src/bno_pkg.sv
src/stream_fifo.sv
src/shtp_link_ctrl.sv
src/sh_report_parser.sv
src/bno085_hub.sv
bench/bno085_hub_sva.sv
bench/bno085_hub_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module bno085_hub_tb \
    -f bno085_hub.f -o bno085_hub_sim &&
./obj_dir/bno085_hub_sim || { echo "simulation run reported an error"; exit 1; }

/* bench/bno085_hub_vectors.txt */
// chan len id x y z w, then expect kind exp_x exp_y exp_z exp_w (hex, kind 0 rotation, 1 gyro)
// Bit 15 of len is the SHTP continuation flag
0003 0012 0005 1234 abcd 0f0f 4000  0001 0000 1234 abcd 0f0f 4000
0005 000e 0002 0010 fff0 7fff 0000  0001 0001 0010 fff0 7fff 0000
0002 0012 0005 1111 2222 3333 4444  0000 0000 0000 0000 0000 0000
0003 0012 0007 5555 6666 7777 8888  0000 0000 0000 0000 0000 0000
0003 000f 0005 0102 0304 0506 0708  0000 0000 0000 0000 0000 0000
0003 0004 0005 1111 2222 3333 4444  0000 0000 0000 0000 0000 0000
0005 0010 0005 8001 7ffe 0000 c000  0001 0000 8001 7ffe 0000 c000
0003 800e 0002 00ff ff00 0102 0000  0001 0001 00ff ff00 0102 0000
0005 0000 0002 1111 2222 3333 4444  0000 0000 0000 0000 0000 0000
0005 000d 0002 1357 2468 9abc 0000  0000 0000 0000 0000 0000 0000
0003 0014 0005 fedc ba98 7654 3210  0001 0000 fedc ba98 7654 3210
0005 000e 0002 8000 0001 ffff 5a5a  0001 0001 8000 0001 ffff 0000
